/* verilog/sift_pixel_pkg.sv */
`default_nettype none

// pixel, DoG and coordinate definitions shared by the datapath
package sift_pixel_pkg;

  // greyscale depth of every pyramid level
  localparam int IMG_BIT_DEPTH = 8;

  // one coordinate, enough for a 256 pixel side
  localparam int COORD_BITS = 8;

  // one extra bit so that the level difference keeps its sign
  localparam int DOG_BITS = IMG_BIT_DEPTH + 1;

  // x, y and the dog image select
  localparam int KEYPOINT_BITS = 2 * COORD_BITS + 1;

  typedef logic [IMG_BIT_DEPTH-1:0] pixel_t;

  // sharper level minus fuzzier level
  typedef logic signed [DOG_BITS-1:0] dog_sample_t;

  // x sits in the top bits of the word
  typedef struct packed {
    logic [COORD_BITS-1:0] x;
    logic [COORD_BITS-1:0] y;
    // 0 selects L1-L2, 1 selects L2-L3
    logic                  dog_index;
  } keypoint_fields_t;

  // fields inside the design, raw word at the top level port
  typedef union packed {
    keypoint_fields_t         fields;
    logic [KEYPOINT_BITS-1:0] raw;
  } keypoint_t;

endpackage

`default_nettype wire

/* verilog/sift_ctrl_pkg.sv */
`default_nettype none

// sequencing definitions for the controller and the raster counter
package sift_ctrl_pkg;

  // top level phases of one run
  typedef enum logic [2:0] {
    IDLE,
    DOG_FILL,
    SCAN,
    EMIT_FIRST,
    EMIT_SECOND,
    FINISH
  } phase_t;

  // 3x3 neighborhood in raster order, 0 is top left
  typedef logic [3:0] nbr_idx_t;

  // center of the neighborhood, also the count of samples read before it
  localparam int NBR_CENTER = 4;

  // bottom right neighbor, last read of a center
  localparam int NBR_LAST = 8;

endpackage

`default_nettype wire

/* verilog/dog_ram_if.sv */
`timescale 1ns/10ps
`default_nettype none

// write and read side of one DoG image RAM
interface dog_ram_if #(
  parameter int DIMENSION = 16
);

  localparam int ADDR_BITS = $clog2(DIMENSION * DIMENSION);

  // write side, filled once per run
  logic                        wr_en;
  logic [ADDR_BITS-1:0]        wr_addr;
  sift_pixel_pkg::dog_sample_t wr_data;

  // read side, one cycle from address to data
  logic [ADDR_BITS-1:0]        rd_addr;
  sift_pixel_pkg::dog_sample_t rd_data;

  modport writer (output wr_en, output wr_addr, output wr_data);

  // the read address comes from the shared raster counter
  modport reader (input rd_data);

  modport ram (
    input  wr_en, input wr_addr, input wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

/* verilog/dog_ram.sv */
`timescale 1ns/10ps
`default_nettype none

// simple dual port RAM holding one DoG image
module dog_ram #(
  parameter int DIMENSION = 16
) (
  input wire     clk,
  dog_ram_if.ram mem
);

  localparam int DEPTH = DIMENSION * DIMENSION;

  // one entry per pixel, raster order
  sift_pixel_pkg::dog_sample_t store [DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (mem.wr_en) begin
      store[mem.wr_addr] <= mem.wr_data;
    end
  end

  // registered read, data follows the address by one cycle
  // a write and a read of the same entry in one cycle return the old value
  always_ff @(posedge clk) begin
    mem.rd_data <= store[mem.rd_addr];
  end

endmodule

`default_nettype wire

/* verilog/dog_compute.sv */
`timescale 1ns/10ps
`default_nettype none

// forms both difference of gaussian images while the pyramid is streamed
module dog_compute #(
  parameter int DIMENSION = 16
) (
  input wire                                     clk,
  input wire                                     arst_n,
  input wire                                     fill_active,
  input wire [$clog2(DIMENSION*DIMENSION)-1:0]   pix_addr,
  input sift_pixel_pkg::pixel_t                  l1_data,
  input sift_pixel_pkg::pixel_t                  l2_data,
  input sift_pixel_pkg::pixel_t                  l3_data,
  dog_ram_if.writer                              first_wr,
  dog_ram_if.writer                              second_wr
);

  localparam int ADDR_BITS = $clog2(DIMENSION * DIMENSION);

  // pyramid data belongs to the address of the previous cycle
  logic                 active_d;
  logic [ADDR_BITS-1:0] addr_d;

  // zero extend both pixels, then subtract in 9 bits
  function automatic sift_pixel_pkg::dog_sample_t dog_diff(
    input sift_pixel_pkg::pixel_t sharper,
    input sift_pixel_pkg::pixel_t fuzzier
  );
    return sift_pixel_pkg::dog_sample_t'({1'b0, sharper})
         - sift_pixel_pkg::dog_sample_t'({1'b0, fuzzier});
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      active_d <= 1'b0;
    end else begin
      active_d <= fill_active;
    end
  end

  // address only matters while active_d is set
  always_ff @(posedge clk) begin
    addr_d <= pix_addr;
  end

  // both images land in the same cycle at the same address
  assign first_wr.wr_en    = active_d;
  assign first_wr.wr_addr  = addr_d;
  assign first_wr.wr_data  = dog_diff(l1_data, l2_data);

  assign second_wr.wr_en   = active_d;
  assign second_wr.wr_addr = addr_d;
  assign second_wr.wr_data = dog_diff(l2_data, l3_data);

endmodule

`default_nettype wire

/* verilog/pixel_scan_counter.sv */
`timescale 1ns/10ps
`default_nettype none

// raster counter for the fill pass and the 3x3 neighbor sweep
module pixel_scan_counter #(
  parameter int DIMENSION = 16
) (
  input wire                                       clk,
  input wire                                       arst_n,
  input sift_ctrl_pkg::phase_t                     phase,
  input wire                                       advance,
  output logic [$clog2(DIMENSION*DIMENSION)-1:0]   pix_addr,
  output sift_ctrl_pkg::nbr_idx_t                  nbr_idx,
  output logic [sift_pixel_pkg::COORD_BITS-1:0]    center_x,
  output logic [sift_pixel_pkg::COORD_BITS-1:0]    center_y,
  output logic                                     fill_last,
  output logic                                     nbr_last,
  output logic                                     scan_last
);

  localparam int ADDR_BITS  = $clog2(DIMENSION * DIMENSION);
  localparam int COORD_BITS = sift_pixel_pkg::COORD_BITS;

  // interior centers run from 1 to DIMENSION-2
  localparam logic [COORD_BITS-1:0] FIRST_CENTER = COORD_BITS'(1);
  localparam logic [COORD_BITS-1:0] LAST_CENTER  = COORD_BITS'(DIMENSION - 2);

  logic [ADDR_BITS-1:0] fill_cnt;
  logic [ADDR_BITS-1:0] scan_addr;

  assign fill_last = (fill_cnt == ADDR_BITS'(DIMENSION * DIMENSION - 1));
  assign nbr_last  = (nbr_idx == 4'(sift_ctrl_pkg::NBR_LAST));
  assign scan_last = (center_x == LAST_CENTER) && (center_y == LAST_CENTER);

  // neighbor address from the center and the row and column offset
  always_comb begin
    int row_off;
    int col_off;
    row_off   = (nbr_idx >= 4'd6) ? 2 : ((nbr_idx >= 4'd3) ? 1 : 0);
    col_off   = int'(nbr_idx) - 3 * row_off;
    scan_addr = ADDR_BITS'((int'(center_y) + row_off - 1) * DIMENSION
                           + int'(center_x) + col_off - 1);
  end

  // pyramid and both RAM reads share this address
  assign pix_addr = (phase == sift_ctrl_pkg::DOG_FILL) ? fill_cnt : scan_addr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fill_cnt <= '0;
      nbr_idx  <= '0;
      center_x <= FIRST_CENTER;
      center_y <= FIRST_CENTER;
    end else if (phase == sift_ctrl_pkg::IDLE) begin
      // rewind for the next run
      fill_cnt <= '0;
      nbr_idx  <= '0;
      center_x <= FIRST_CENTER;
      center_y <= FIRST_CENTER;
    end else if (advance) begin
      if (phase == sift_ctrl_pkg::DOG_FILL) begin
        fill_cnt <= fill_last ? '0 : fill_cnt + 1'b1;
      end else if (nbr_last) begin
        // neighborhood done, move to the next center, x is the inner loop
        nbr_idx <= '0;
        if (center_x == LAST_CENTER) begin
          center_x <= FIRST_CENTER;
          center_y <= center_y + 1'b1;
        end else begin
          center_x <= center_x + 1'b1;
        end
      end else begin
        nbr_idx <= nbr_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/extrema_check.sv */
`timescale 1ns/10ps
`default_nettype none

// extremum test of one center over its 3x3 neighborhood in both DoG images
module extrema_check (
  input wire                      clk,
  input wire                      arst_n,
  input wire                      sample_en,
  input sift_ctrl_pkg::nbr_idx_t  nbr_idx,
  dog_ram_if.reader               first_rd,
  dog_ram_if.reader               second_rd,
  output logic                    first_is_extremum,
  output logic                    second_is_extremum
);

  localparam int NBR_CENTER = sift_ctrl_pkg::NBR_CENTER;

  // read request delayed to line up with RAM data
  logic                     en_d;
  sift_ctrl_pkg::nbr_idx_t  idx_d;

  // index 0 is the first image, 1 the second
  sift_pixel_pkg::dog_sample_t sample [2];
  // neighbors 0..3 arrive before the center
  sift_pixel_pkg::dog_sample_t early  [2][NBR_CENTER];
  sift_pixel_pkg::dog_sample_t center [2];

  // center above or below everything compared so far
  logic [1:0] above;
  logic [1:0] below;
  // state at the moment the center arrives
  logic [1:0] start_gt;
  logic [1:0] start_lt;
  // result including the final neighbor
  logic [1:0] flag;

  always_comb begin
    sample[0] = first_rd.rd_data;
    sample[1] = second_rd.rd_data;
    for (int img = 0; img < 2; img++) begin
      // in the center cycle sample holds the center itself
      // cross image compare against the other center
      start_gt[img] = sample[img] > sample[1-img];
      start_lt[img] = sample[img] < sample[1-img];
      for (int k = 0; k < NBR_CENTER; k++) begin
        start_gt[img] = start_gt[img] & (sample[img] > early[img][k]);
        start_lt[img] = start_lt[img] & (sample[img] < early[img][k]);
      end
      // strict on every comparand
      flag[img] = (above[img] && (center[img] > sample[img]))
               || (below[img] && (center[img] < sample[img]));
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      en_d  <= 1'b0;
      idx_d <= '0;
      above <= '0;
      below <= '0;
    end else begin
      en_d  <= sample_en;
      idx_d <= nbr_idx;
      if (en_d && (idx_d == 4'(NBR_CENTER))) begin
        above <= start_gt;
        below <= start_lt;
      end else if (en_d && (idx_d > 4'(NBR_CENTER))) begin
        // neighbors after the center, narrow both trackers
        for (int img = 0; img < 2; img++) begin
          above[img] <= above[img] && (center[img] > sample[img]);
          below[img] <= below[img] && (center[img] < sample[img]);
        end
      end
    end
  end

  // sample buffers, overwritten for each center
  always_ff @(posedge clk) begin
    for (int img = 0; img < 2; img++) begin
      if (en_d && (idx_d < 4'(NBR_CENTER))) begin
        early[img][idx_d[1:0]] <= sample[img];
      end
      if (en_d && (idx_d == 4'(NBR_CENTER))) begin
        center[img] <= sample[img];
      end
    end
  end

  // valid only in the evaluation cycle, when the last neighbor is on rd_data
  assign first_is_extremum  = en_d && (idx_d == 4'(sift_ctrl_pkg::NBR_LAST)) && flag[0];
  assign second_is_extremum = en_d && (idx_d == 4'(sift_ctrl_pkg::NBR_LAST)) && flag[1];

endmodule

`default_nettype wire

/* verilog/keypoint_control.sv */
`timescale 1ns/10ps
`default_nettype none

// phase FSM, keypoint output handshake and done pulse
module keypoint_control (
  input wire                                    clk,
  input wire                                    arst_n,
  input wire                                    start,
  input wire                                    fill_last,
  input wire                                    nbr_last,
  input wire                                    scan_last,
  input wire                                    first_is_extremum,
  input wire                                    second_is_extremum,
  input wire [sift_pixel_pkg::COORD_BITS-1:0]   center_x,
  input wire [sift_pixel_pkg::COORD_BITS-1:0]   center_y,
  input wire                                    keypoint_ready,
  output sift_ctrl_pkg::phase_t                 phase,
  output logic                                  advance,
  output logic                                  fill_active,
  output logic                                  sample_en,
  output logic                                  busy,
  output logic                                  done,
  output logic                                  keypoint_valid,
  output sift_pixel_pkg::keypoint_t             keypoint_data
);

  sift_ctrl_pkg::phase_t phase_d;

  // last write of the fill pass is still in flight
  logic fill_drain;
  // all nine reads issued, flags are valid this cycle
  logic eval_cycle;
  // second image also flagged while the first is on the output
  logic second_pending;

  always_comb begin
    phase_d     = phase;
    advance     = 1'b0;
    fill_active = 1'b0;
    sample_en   = 1'b0;
    case (phase)
      sift_ctrl_pkg::IDLE: begin
        if (start) begin
          phase_d = sift_ctrl_pkg::DOG_FILL;
        end
      end
      sift_ctrl_pkg::DOG_FILL: begin
        if (!fill_drain) begin
          fill_active = 1'b1;
          advance     = 1'b1;
        end else begin
          phase_d = sift_ctrl_pkg::SCAN;
        end
      end
      sift_ctrl_pkg::SCAN: begin
        if (!eval_cycle) begin
          // hold on the last neighbor so the center stays for evaluation
          sample_en = 1'b1;
          advance   = !nbr_last;
        end else if (first_is_extremum) begin
          phase_d = sift_ctrl_pkg::EMIT_FIRST;
        end else if (second_is_extremum) begin
          phase_d = sift_ctrl_pkg::EMIT_SECOND;
        end else begin
          advance = 1'b1;
          if (scan_last) begin
            phase_d = sift_ctrl_pkg::FINISH;
          end
        end
      end
      sift_ctrl_pkg::EMIT_FIRST: begin
        if (keypoint_ready) begin
          if (second_pending) begin
            phase_d = sift_ctrl_pkg::EMIT_SECOND;
          end else begin
            advance = 1'b1;
            phase_d = scan_last ? sift_ctrl_pkg::FINISH : sift_ctrl_pkg::SCAN;
          end
        end
      end
      sift_ctrl_pkg::EMIT_SECOND: begin
        // counter frozen until the word is taken
        if (keypoint_ready) begin
          advance = 1'b1;
          phase_d = scan_last ? sift_ctrl_pkg::FINISH : sift_ctrl_pkg::SCAN;
        end
      end
      default: begin
        phase_d = sift_ctrl_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase          <= sift_ctrl_pkg::IDLE;
      fill_drain     <= 1'b0;
      eval_cycle     <= 1'b0;
      second_pending <= 1'b0;
    end else begin
      phase      <= phase_d;
      fill_drain <= (phase == sift_ctrl_pkg::DOG_FILL) && !fill_drain && fill_last;
      eval_cycle <= (phase == sift_ctrl_pkg::SCAN) && !eval_cycle && nbr_last;
      if ((phase == sift_ctrl_pkg::SCAN) && eval_cycle) begin
        second_pending <= second_is_extremum;
      end
    end
  end

  // status decoded from the phase register
  assign busy           = (phase != sift_ctrl_pkg::IDLE);
  assign done           = (phase == sift_ctrl_pkg::FINISH);
  assign keypoint_valid = (phase == sift_ctrl_pkg::EMIT_FIRST)
                       || (phase == sift_ctrl_pkg::EMIT_SECOND);

  // center held by the frozen counter, so the word is stable while valid
  always_comb begin
    keypoint_data.fields.x         = center_x;
    keypoint_data.fields.y         = center_y;
    keypoint_data.fields.dog_index = (phase == sift_ctrl_pkg::EMIT_SECOND);
  end

endmodule

`default_nettype wire

/* verilog/find_keypoints.sv */
`timescale 1ns/10ps
`default_nettype none

// keypoint finder for one octave, three gaussian levels in, keypoints out
module find_keypoints #(
  parameter int DIMENSION = 16,
  localparam int ADDR_BITS = $clog2(DIMENSION * DIMENSION)
) (
  input wire                                          clk,
  input wire                                          arst_n,
  input wire                                          start,
  output logic                                        busy,
  output logic                                        done,
  // shared read address of the three pyramid levels
  output logic [ADDR_BITS-1:0]                        pyr_addr,
  input sift_pixel_pkg::pixel_t                       l1_data,
  input sift_pixel_pkg::pixel_t                       l2_data,
  input sift_pixel_pkg::pixel_t                       l3_data,
  // keypoint stream
  output logic                                        keypoint_valid,
  input wire                                          keypoint_ready,
  output logic [sift_pixel_pkg::KEYPOINT_BITS-1:0]    keypoint_data
);

  sift_ctrl_pkg::phase_t                   phase;
  sift_ctrl_pkg::nbr_idx_t                 nbr_idx;
  logic [ADDR_BITS-1:0]                    pix_addr;
  logic [sift_pixel_pkg::COORD_BITS-1:0]   center_x;
  logic [sift_pixel_pkg::COORD_BITS-1:0]   center_y;
  logic                                    advance;
  logic                                    fill_active;
  logic                                    sample_en;
  logic                                    fill_last;
  logic                                    nbr_last;
  logic                                    scan_last;
  logic                                    first_is_extremum;
  logic                                    second_is_extremum;
  sift_pixel_pkg::keypoint_t               keypoint;

  // L1-L2 and L2-L3 images
  dog_ram_if #(.DIMENSION(DIMENSION)) dog_first ();
  dog_ram_if #(.DIMENSION(DIMENSION)) dog_second ();

  // one counter addresses the pyramid and both RAMs
  assign pyr_addr           = pix_addr;
  assign dog_first.rd_addr  = pix_addr;
  assign dog_second.rd_addr = pix_addr;

  assign keypoint_data = keypoint.raw;

  dog_ram #(.DIMENSION(DIMENSION)) u_ram_first  (.clk(clk), .mem(dog_first.ram));
  dog_ram #(.DIMENSION(DIMENSION)) u_ram_second (.clk(clk), .mem(dog_second.ram));

  dog_compute #(.DIMENSION(DIMENSION)) u_dog_compute (
    .clk(clk), .arst_n(arst_n), .fill_active(fill_active), .pix_addr(pix_addr),
    .l1_data(l1_data), .l2_data(l2_data), .l3_data(l3_data),
    .first_wr(dog_first.writer), .second_wr(dog_second.writer)
  );

  pixel_scan_counter #(.DIMENSION(DIMENSION)) u_counter (
    .clk(clk), .arst_n(arst_n), .phase(phase), .advance(advance),
    .pix_addr(pix_addr), .nbr_idx(nbr_idx), .center_x(center_x), .center_y(center_y),
    .fill_last(fill_last), .nbr_last(nbr_last), .scan_last(scan_last)
  );

  extrema_check u_extrema (
    .clk(clk), .arst_n(arst_n), .sample_en(sample_en), .nbr_idx(nbr_idx),
    .first_rd(dog_first.reader), .second_rd(dog_second.reader),
    .first_is_extremum(first_is_extremum), .second_is_extremum(second_is_extremum)
  );

  keypoint_control u_control (
    .clk(clk), .arst_n(arst_n), .start(start),
    .fill_last(fill_last), .nbr_last(nbr_last), .scan_last(scan_last),
    .first_is_extremum(first_is_extremum), .second_is_extremum(second_is_extremum),
    .center_x(center_x), .center_y(center_y), .keypoint_ready(keypoint_ready),
    .phase(phase), .advance(advance), .fill_active(fill_active), .sample_en(sample_en),
    .busy(busy), .done(done), .keypoint_valid(keypoint_valid), .keypoint_data(keypoint)
  );

endmodule

`default_nettype wire

/* verification/find_keypoints_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module find_keypoints_tb;

  localparam int DIMENSION  = 16;
  localparam int N          = DIMENSION * DIMENSION;
  localparam int ADDR_BITS  = $clog2(N);
  localparam int COORD_BITS = sift_pixel_pkg::COORD_BITS;
  // each run gets four times the fill pass plus ten cycles per interior center
  localparam int CENTERS         = (DIMENSION - 2) * (DIMENSION - 2);
  localparam int RUN_CYCLES      = 4 * (N + CENTERS * 10);
  localparam int NUM_RUNS        = 5;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_CYCLES + 1000;

  logic                                     clk = 1'b0;
  logic                                     arst_n;
  logic                                     start;
  logic                                     busy;
  logic                                     done;
  logic [ADDR_BITS-1:0]                     pyr_addr;
  sift_pixel_pkg::pixel_t                   l1_data;
  sift_pixel_pkg::pixel_t                   l2_data;
  sift_pixel_pkg::pixel_t                   l3_data;
  logic                                     keypoint_valid;
  logic                                     keypoint_ready;
  logic [sift_pixel_pkg::KEYPOINT_BITS-1:0] keypoint_data;

  // pyramid levels as seen by the DUT
  sift_pixel_pkg::pixel_t lvl1 [N];
  sift_pixel_pkg::pixel_t lvl2 [N];
  sift_pixel_pkg::pixel_t lvl3 [N];
  logic [ADDR_BITS-1:0]   addr_q;

  integer                    seed = 38;
  string                     test_name = "reset";
  bit                        random_ready = 1'b0;
  int                        done_count = 0;
  sift_pixel_pkg::keypoint_t expected [$];
  sift_pixel_pkg::keypoint_t received [$];

  // previous negedge view of the output stream
  logic                      prev_valid = 1'b0;
  logic                      prev_ready = 1'b0;
  sift_pixel_pkg::keypoint_t prev_data;

  find_keypoints #(.DIMENSION(DIMENSION)) UUT (
    .clk(clk), .arst_n(arst_n), .start(start), .busy(busy), .done(done),
    .pyr_addr(pyr_addr), .l1_data(l1_data), .l2_data(l2_data), .l3_data(l3_data),
    .keypoint_valid(keypoint_valid), .keypoint_ready(keypoint_ready),
    .keypoint_data(keypoint_data)
  );

  always #4 clk = ~clk;

  task automatic check_keypoint(input string name, input sift_pixel_pkg::keypoint_t exp_kp,
                                input sift_pixel_pkg::keypoint_t act_kp);
    if (exp_kp !== act_kp) begin
      $display("CHECK FAILED %s: expected x=%0d y=%0d dog=%0d, actual x=%0d y=%0d dog=%0d",
               name, exp_kp.fields.x, exp_kp.fields.y, exp_kp.fields.dog_index,
               act_kp.fields.x, act_kp.fields.y, act_kp.fields.dog_index);
      $display("Some tests failed");
      $fatal(1, "keypoint mismatch");
    end
  endtask

  task automatic check_count(input string name, input int exp_n, input int act_n);
    if (exp_n != act_n) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp_n, act_n);
      $display("Some tests failed");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp_b, input logic act_b);
    if (exp_b !== act_b) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp_b, act_b);
      $display("Some tests failed");
      $fatal(1, "status bit mismatch");
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_BITS-1:0] exp_a,
                            input logic [ADDR_BITS-1:0] act_a);
    if (exp_a !== act_a) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp_a, act_a);
      $display("Some tests failed");
      $fatal(1, "address mismatch");
    end
  endtask

  // pyramid address sampled mid cycle and answered after the next edge
  always @(negedge clk) begin
    addr_q = pyr_addr;
  end

  always @(posedge clk) begin
    #1;
    l1_data <= lvl1[addr_q];
    l2_data <= lvl2[addr_q];
    l3_data <= lvl3[addr_q];
    // about half the cycles stall the output under back-pressure
    if (random_ready) begin
      keypoint_ready <= (($random(seed) % 2) != 0);
    end else begin
      keypoint_ready <= 1'b1;
    end
  end

  // valid, ready and data are settled at the falling edge
  always @(negedge clk) begin
    sift_pixel_pkg::keypoint_t actual;
    actual.raw = keypoint_data;
    if (arst_n) begin
      if (prev_valid && !prev_ready) begin
        check_bit({test_name, " valid hold"}, 1'b1, keypoint_valid);
        check_keypoint({test_name, " data hold"}, prev_data, actual);
      end
      if (keypoint_valid && keypoint_ready) begin
        if (received.size() >= expected.size()) begin
          $display("%s: DUT sent more keypoints than the model predicts", test_name);
          $display("Some tests failed");
          $fatal(1, "extra keypoint");
        end else begin
          check_keypoint(test_name, expected[received.size()], actual);
          received.push_back(actual);
        end
      end
      if (done) begin
        done_count++;
      end
    end
    prev_valid = keypoint_valid;
    prev_ready = keypoint_ready;
    prev_data  = actual;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: done never arrived within %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  task automatic fill_random();
    for (int i = 0; i < N; i++) begin
      lvl1[i] = sift_pixel_pkg::pixel_t'($random(seed));
      lvl2[i] = sift_pixel_pkg::pixel_t'($random(seed));
      lvl3[i] = sift_pixel_pkg::pixel_t'($random(seed));
    end
  endtask

  task automatic fill_constant(input int v1, input int v2, input int v3);
    for (int i = 0; i < N; i++) begin
      lvl1[i] = sift_pixel_pkg::pixel_t'(v1);
      lvl2[i] = sift_pixel_pkg::pixel_t'(v2);
      lvl3[i] = sift_pixel_pkg::pixel_t'(v3);
    end
  endtask

  // reference model scanning y then x with the first image before the second
  task automatic build_expected();
    int                        dog [2][N];
    int                        c;
    int                        nb;
    bit                        gt;
    bit                        lt;
    sift_pixel_pkg::keypoint_t kp;
    expected.delete();
    for (int i = 0; i < N; i++) begin
      dog[0][i] = int'(lvl1[i]) - int'(lvl2[i]);
      dog[1][i] = int'(lvl2[i]) - int'(lvl3[i]);
    end
    for (int y = 1; y <= DIMENSION - 2; y++) begin
      for (int x = 1; x <= DIMENSION - 2; x++) begin
        for (int img = 0; img < 2; img++) begin
          c = dog[img][y * DIMENSION + x];
          // other image's center counts as the ninth comparand
          gt = c > dog[1 - img][y * DIMENSION + x];
          lt = c < dog[1 - img][y * DIMENSION + x];
          for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
              if (dy != 0 || dx != 0) begin
                nb = dog[img][(y + dy) * DIMENSION + x + dx];
                gt = gt && (c > nb);
                lt = lt && (c < nb);
              end
            end
          end
          if (gt || lt) begin
            kp.fields.x         = COORD_BITS'(x);
            kp.fields.y         = COORD_BITS'(y);
            kp.fields.dog_index = (img == 1);
            expected.push_back(kp);
          end
        end
      end
    end
  endtask

  // called on a rising edge with the DUT idle
  task automatic run_test(input string name, input bit backpressure, input bit extra_start);
    test_name = name;
    build_expected();
    received.delete();
    done_count   = 0;
    random_ready = backpressure;
    #1;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    // fill pass streams the whole image once in raster order
    for (int i = 0; i < N; i++) begin
      @(negedge clk);
      check_addr({name, " fill address"}, ADDR_BITS'(i), pyr_addr);
    end
    if (extra_start) begin
      // lands mid scan after the first keypoints have gone out
      repeat (400) @(posedge clk);
      #1;
      check_bit({name, " busy at second start"}, 1'b1, busy);
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
    end
    while (done_count == 0) @(posedge clk);
    @(negedge clk);
    check_bit({name, " busy after done"}, 1'b0, busy);
    random_ready = 1'b0;
    repeat (10) @(posedge clk);
    check_count({name, " done pulses"}, 1, done_count);
    check_count({name, " keypoints"}, expected.size(), received.size());
  endtask

  initial begin
    sift_pixel_pkg::keypoint_t planted;
    arst_n         = 1'b0;
    start          = 1'b0;
    keypoint_ready = 1'b1;
    l1_data        = '0;
    l2_data        = '0;
    l3_data        = '0;
    addr_q         = '0;
    fill_constant(0, 0, 0);
    repeat (5) @(posedge clk);
    // status outputs quiet while in reset
    check_bit("reset busy", 1'b0, busy);
    check_bit("reset done", 1'b0, done);
    check_bit("reset keypoint valid", 1'b0, keypoint_valid);
    #1;
    arst_n = 1'b1;
    @(posedge clk);

    fill_random();
    run_test("random ready high", 1'b0, 1'b0);

    fill_random();
    run_test("random back-pressure", 1'b1, 1'b0);

    // equal DoG values everywhere
    fill_constant(120, 90, 60);
    run_test("constant image", 1'b0, 1'b0);

    // bright spot in the sharpest level only
    fill_constant(100, 100, 100);
    lvl1[9 * DIMENSION + 5] = 8'd255;
    run_test("planted pixel", 1'b0, 1'b0);
    planted.fields.x         = COORD_BITS'(5);
    planted.fields.y         = COORD_BITS'(9);
    planted.fields.dog_index = 1'b0;
    check_count("planted pixel count", 1, received.size());
    check_keypoint("planted pixel position", planted, received[0]);

    fill_random();
    run_test("start while busy", 1'b0, 1'b1);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
verilog/sift_pixel_pkg.sv
verilog/sift_ctrl_pkg.sv
verilog/dog_ram_if.sv
verilog/dog_ram.sv
verilog/dog_compute.sv
verilog/pixel_scan_counter.sv
verilog/extrema_check.sv
verilog/keypoint_control.sv
verilog/find_keypoints.sv
verification/find_keypoints_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the keypoint finder testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f \
  --top-module find_keypoints_tb -o find_keypoints_sim

# a failing run still prints its output before the verdict
output=$(./obj_dir/find_keypoints_sim 2>&1) || true
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1
